/* hdl/rv32m_config.svh */
`ifndef RV32M_CONFIG_SVH
`define RV32M_CONFIG_SVH

// width of the physical destination register tag.
`define MDU_TAG_BITS 6

// partial-product steps in mult_seq, one of 1, 3 or 11.
`define MULT_CYCLES 3

// operand width.
`define XLEN 32

`endif

/* hdl/rv32m_pkg.sv */
`default_nettype none

package rv32m_pkg;

    // *******************************************************************
    // instruction word
    // *******************************************************************

    // one word seen either raw or through the R-type fields.
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
    } instr_u;

    // *******************************************************************
    // encodings
    // *******************************************************************

    localparam logic [6:0] OP_REG        = 7'b0110011;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // bit 2 set selects the divider.
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;
    localparam logic [2:0] F3_DIV    = 3'b100;
    localparam logic [2:0] F3_DIVU   = 3'b101;
    localparam logic [2:0] F3_REM    = 3'b110;
    localparam logic [2:0] F3_REMU   = 3'b111;

endpackage : rv32m_pkg

`default_nettype wire

/* hdl/mult_seq.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv32m_config.svh"

module mult_seq (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic [`XLEN:0]      a,
    input  logic [`XLEN:0]      b,
    output logic                complete,
    output logic [2*`XLEN+1:0]  product
);

    localparam int OPW   = `XLEN + 1;
    localparam int SLICE = OPW / `MULT_CYCLES;
    localparam int CW    = $clog2(`MULT_CYCLES + 1);

    localparam logic [CW-1:0] LAST_STEP = CW'(`MULT_CYCLES - 1);
    localparam logic [CW-1:0] STEPS     = CW'(`MULT_CYCLES);

    logic              run;
    logic [CW-1:0]     cnt;
    logic [2*OPW-1:0]  a_sh;
    logic [OPW-1:0]    b_sh;
    logic [2*OPW-1:0]  acc;
    logic [2*OPW-1:0]  slice_ext;
    logic [2*OPW-1:0]  partial;

    // the top slice of b carries the sign, lower slices are unsigned.
    always_comb begin
        slice_ext = {{(2*OPW-SLICE){(cnt == LAST_STEP) & b_sh[SLICE-1]}}, b_sh[SLICE-1:0]};
        partial   = a_sh * slice_ext;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run      <= 1'b0;
            cnt      <= '0;
            complete <= 1'b0;
        end else begin
            complete <= 1'b0;
            if (start) begin
                run <= 1'b1;
                cnt <= '0;
            end else if (run) begin
                if (cnt == STEPS) begin
                    run      <= 1'b0;
                    complete <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // a moves up one slice per step while b moves down.
    always_ff @(posedge clk) begin
        if (start) begin
            a_sh <= {{OPW{a[OPW-1]}}, a};
            b_sh <= b;
            acc  <= '0;
        end else if (run && cnt != STEPS) begin
            acc  <= acc + partial;
            a_sh <= a_sh << SLICE;
            b_sh <= b_sh >> SLICE;
        end
    end

    assign product = acc;

    // sampled complete trails the sampled start by the step count plus two edges.
    complete_latency: assert property (@(posedge clk) disable iff (!rst_n)
        complete |-> $past(start, `MULT_CYCLES + 2))
        else $error("mult_seq complete without a matching start");

endmodule : mult_seq

`default_nettype wire

/* hdl/fu_mult.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv32m_config.svh"

module fu_mult (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [`XLEN-1:0]  rs1_v,
    input  logic [`XLEN-1:0]  rs2_v,
    input  logic [2:0]        funct3,
    output logic [`XLEN-1:0]  rd_v,
    output logic              complete
);

    logic                a_signed;
    logic                b_signed;
    logic [`XLEN:0]      a_final;
    logic [`XLEN:0]      b_final;
    logic                complete_inst;
    logic [2*`XLEN+1:0]  product_inst;

    // *******************************************************************
    // operand extension
    // *******************************************************************

    // only MULHU treats rs1 as unsigned.
    always_comb begin
        a_signed = (funct3 != rv32m_pkg::F3_MULHU);
        b_signed = (funct3 == rv32m_pkg::F3_MUL) || (funct3 == rv32m_pkg::F3_MULH);
        a_final  = {a_signed & rs1_v[`XLEN-1], rs1_v};
        b_final  = {b_signed & rs2_v[`XLEN-1], rs2_v};
    end

    mult_seq u_mult_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .a        (a_final),
        .b        (b_final),
        .complete (complete_inst),
        .product  (product_inst)
    );

    // *******************************************************************
    // result select
    // *******************************************************************

    always_comb begin
        if (funct3 == rv32m_pkg::F3_MUL) begin
            rd_v = product_inst[`XLEN-1:0];
        end else begin
            rd_v = product_inst[2*`XLEN-1:`XLEN];
        end
    end

    assign complete = complete_inst;

endmodule : fu_mult

`default_nettype wire

/* hdl/fu_div.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv32m_config.svh"

module fu_div (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [`XLEN-1:0]  rs1_v,
    input  logic [`XLEN-1:0]  rs2_v,
    input  logic [2:0]        funct3,
    output logic [`XLEN-1:0]  rd_v,
    output logic              complete
);

    localparam int CW = $clog2(`XLEN + 2);

    // steps run while cnt is below FIX_STEP.
    localparam logic [CW-1:0] FIX_STEP = CW'(`XLEN);
    localparam logic [CW-1:0] OUT_STEP = CW'(`XLEN + 1);

    logic              run;
    logic [CW-1:0]     cnt;
    logic              signed_op;
    logic [`XLEN-1:0]  a_mag;
    logic [`XLEN-1:0]  b_mag;
    logic [`XLEN+1:0]  diff;
    logic [`XLEN-1:0]  quo;
    logic [`XLEN-1:0]  rem;
    logic [`XLEN-1:0]  dvs;
    logic [`XLEN-1:0]  dividend_r;
    logic              neg_q;
    logic              neg_r;
    logic              is_rem;
    logic              div_zero;
    logic              ovf;

    always_comb begin
        signed_op = (funct3 == rv32m_pkg::F3_DIV) || (funct3 == rv32m_pkg::F3_REM);
        a_mag     = (signed_op && rs1_v[`XLEN-1]) ? -rs1_v : rs1_v;
        b_mag     = (signed_op && rs2_v[`XLEN-1]) ? -rs2_v : rs2_v;
        // trial subtract with the borrow in the top bit.
        diff      = {1'b0, rem, quo[`XLEN-1]} - {2'b00, dvs};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run      <= 1'b0;
            cnt      <= '0;
            complete <= 1'b0;
        end else begin
            complete <= 1'b0;
            if (start) begin
                run <= 1'b1;
                cnt <= '0;
            end else if (run) begin
                if (cnt == OUT_STEP) begin
                    run      <= 1'b0;
                    complete <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // *******************************************************************
    // datapath
    // *******************************************************************

    always_ff @(posedge clk) begin
        if (start) begin
            quo        <= a_mag;
            rem        <= '0;
            dvs        <= b_mag;
            dividend_r <= rs1_v;
            neg_q      <= signed_op && (rs1_v[`XLEN-1] ^ rs2_v[`XLEN-1]);
            neg_r      <= signed_op && rs1_v[`XLEN-1];
            is_rem     <= (funct3 == rv32m_pkg::F3_REM) || (funct3 == rv32m_pkg::F3_REMU);
            div_zero   <= (rs2_v == '0);
            ovf        <= signed_op && (rs1_v == {1'b1, {(`XLEN-1){1'b0}}}) && (rs2_v == '1);
        end else if (run) begin
            if (cnt < FIX_STEP) begin
                if (!diff[`XLEN+1]) begin
                    rem <= diff[`XLEN-1:0];
                    quo <= {quo[`XLEN-2:0], 1'b1};
                end else begin
                    rem <= {rem[`XLEN-2:0], quo[`XLEN-1]};
                    quo <= {quo[`XLEN-2:0], 1'b0};
                end
            end else if (cnt == FIX_STEP) begin
                // sign correction.
                quo <= neg_q ? -quo : quo;
                rem <= neg_r ? -rem : rem;
            end else if (div_zero) begin
                rd_v <= is_rem ? dividend_r : '1;
            end else if (ovf) begin
                rd_v <= is_rem ? '0 : dividend_r;
            end else begin
                rd_v <= is_rem ? rem : quo;
            end
        end
    end

    // sampled complete trails the sampled start by the step count plus three edges.
    complete_latency: assert property (@(posedge clk) disable iff (!rst_n)
        complete |-> $past(start, `XLEN + 3))
        else $error("fu_div complete without a matching start");

endmodule : fu_div

`default_nettype wire

/* hdl/mdu_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv32m_config.svh"

module mdu_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  rv32m_pkg::instr_u         instr,
    input  logic [`XLEN-1:0]          rs1_v,
    input  logic [`XLEN-1:0]          rs2_v,
    input  logic [`MDU_TAG_BITS-1:0]  tag_in,
    output logic                      busy,
    output logic                      done,
    output logic                      illegal,
    output logic [`XLEN-1:0]          rd_v,
    output logic [`MDU_TAG_BITS-1:0]  tag_out
);

    logic                      accept;
    logic                      legal;
    logic                      finish;
    logic                      mult_go;
    logic                      div_go;
    logic                      ill_go;
    logic [`XLEN-1:0]          rs1_r;
    logic [`XLEN-1:0]          rs2_r;
    logic [2:0]                funct3_r;
    logic [`MDU_TAG_BITS-1:0]  tag_r;
    logic [`XLEN-1:0]          mult_rd_v;
    logic [`XLEN-1:0]          div_rd_v;
    logic                      mult_complete;
    logic                      div_complete;

    assign accept = start && !busy;
    assign legal  = (instr.r.opcode == rv32m_pkg::OP_REG) &&
                    (instr.r.funct7 == rv32m_pkg::FUNCT7_MULDIV);
    assign finish = ill_go || mult_complete || div_complete;

    always_ff @(posedge clk) begin
        if (accept) begin
            rs1_r    <= rs1_v;
            rs2_r    <= rs2_v;
            funct3_r <= instr.r.funct3;
            tag_r    <= tag_in;
        end
    end

    // *******************************************************************
    // accept, dispatch and completion
    // *******************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            mult_go <= 1'b0;
            div_go  <= 1'b0;
            ill_go  <= 1'b0;
            done    <= 1'b0;
            illegal <= 1'b0;
            rd_v    <= '0;
            tag_out <= '0;
        end else begin
            mult_go <= accept && legal && !instr.r.funct3[2];
            div_go  <= accept && legal && instr.r.funct3[2];
            ill_go  <= accept && !legal;
            done    <= finish;
            if (accept) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;
            end
            if (finish) begin
                illegal <= ill_go;
                tag_out <= tag_r;
                if (ill_go) begin
                    rd_v <= '0;
                end else if (mult_complete) begin
                    rd_v <= mult_rd_v;
                end else begin
                    rd_v <= div_rd_v;
                end
            end
        end
    end

    fu_mult u_fu_mult (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (mult_go),
        .rs1_v    (rs1_r),
        .rs2_v    (rs2_r),
        .funct3   (funct3_r),
        .rd_v     (mult_rd_v),
        .complete (mult_complete)
    );

    fu_div u_fu_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (div_go),
        .rs1_v    (rs1_r),
        .rs2_v    (rs2_r),
        .funct3   (funct3_r),
        .rd_v     (div_rd_v),
        .complete (div_complete)
    );

    no_start_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy)
        else $error("start raised while the unit is busy");

endmodule : mdu_top

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset leaves a little after a rising edge.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule : tb_clock

`default_nettype wire

/* tests/tb_mdu.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv32m_config.svh"

module tb_mdu;

    localparam int DRIVE_DELAY = 2;
    localparam int TAG_BITS    = `MDU_TAG_BITS;
    localparam int MUL_LAT     = `MULT_CYCLES + 3;
    localparam int DIV_LAT     = `XLEN + 4;
    localparam int NUM_RANDOM  = 100;
    localparam int NUM_OPS     = 5 * 5 * 8 + 8 * NUM_RANDOM + 12 + 8 + 20;
    localparam int CYCLE_LIMIT = 40 * NUM_OPS + 100;

    logic                      clk;
    logic                      rst_n;
    logic                      start;
    rv32m_pkg::instr_u         instr;
    logic [`XLEN-1:0]          rs1_v;
    logic [`XLEN-1:0]          rs2_v;
    logic [`MDU_TAG_BITS-1:0]  tag_in;
    logic                      busy;
    logic                      done;
    logic                      illegal;
    logic [`XLEN-1:0]          rd_v;
    logic [`MDU_TAG_BITS-1:0]  tag_out;

    integer                    seed;
    int                        cycle_cnt;
    int                        error_count;
    int                        run_errors;
    int                        check_count;
    int                        op_count;
    logic [`XLEN-1:0]          corner [5];

    // expected results, oldest operation first.
    int                        start_q [$];
    int                        lat_q [$];
    logic [`XLEN-1:0]          rd_q [$];
    logic                      ill_q [$];
    logic [`MDU_TAG_BITS-1:0]  tag_q [$];

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mdu_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .instr   (instr),
        .rs1_v   (rs1_v),
        .rs2_v   (rs2_v),
        .tag_in  (tag_in),
        .busy    (busy),
        .done    (done),
        .illegal (illegal),
        .rd_v    (rd_v),
        .tag_out (tag_out)
    );

    // *******************************************************************
    // reference model
    // *******************************************************************

    function automatic void mdu_model(
        input  rv32m_pkg::instr_u  word,
        input  logic [31:0]        a,
        input  logic [31:0]        b,
        output logic [31:0]        res,
        output logic               ill
    );
        longint       sa;
        longint       sb;
        longint       ua;
        longint       ub;
        logic [63:0]  prod;
        logic         ovf;
        ill  = !((word.r.opcode == rv32m_pkg::OP_REG) &&
                 (word.r.funct7 == rv32m_pkg::FUNCT7_MULDIV));
        sa   = longint'($signed(a));
        sb   = longint'($signed(b));
        ua   = longint'(a);
        ub   = longint'(b);
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        prod = '0;
        res  = '0;
        case (word.r.funct3)
            rv32m_pkg::F3_MUL: begin
                prod = sa * sb;
                res  = prod[31:0];
            end
            rv32m_pkg::F3_MULH: begin
                prod = sa * sb;
                res  = prod[63:32];
            end
            rv32m_pkg::F3_MULHSU: begin
                prod = sa * ub;
                res  = prod[63:32];
            end
            rv32m_pkg::F3_MULHU: begin
                prod = ua * ub;
                res  = prod[63:32];
            end
            rv32m_pkg::F3_DIV: begin
                res = (b == 32'h0) ? 32'hffff_ffff : (ovf ? a : 32'(sa / sb));
            end
            rv32m_pkg::F3_DIVU: begin
                res = (b == 32'h0) ? 32'hffff_ffff : a / b;
            end
            rv32m_pkg::F3_REM: begin
                res = (b == 32'h0) ? a : (ovf ? 32'h0 : 32'(sa % sb));
            end
            default: begin
                res = (b == 32'h0) ? a : a % b;
            end
        endcase
        if (ill) begin
            res = '0;
        end
    endfunction

    function automatic rv32m_pkg::instr_u encode_r(
        input logic [6:0] f7,
        input logic [2:0] f3,
        input logic [6:0] opcode
    );
        rv32m_pkg::instr_u word;
        word.raw      = '0;
        word.r.funct7 = f7;
        word.r.rs2    = 5'd12;
        word.r.rs1    = 5'd11;
        word.r.funct3 = f3;
        word.r.rd     = 5'd10;
        word.r.opcode = opcode;
        return word;
    endfunction

    function automatic logic [`MDU_TAG_BITS-1:0] random_tag();
        return TAG_BITS'($random(seed));
    endfunction

    task automatic compare_word(
        input string        name,
        input logic [31:0]  got,
        input logic [31:0]  expected
    );
        check_count++;
        assert (got === expected) else begin
            error_count++;
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // *******************************************************************
    // stimulus helpers
    // *******************************************************************

    // called a little after a rising edge with busy low, returns in the done cycle.
    task automatic issue_op(
        input rv32m_pkg::instr_u          word,
        input logic [31:0]                a,
        input logic [31:0]                b,
        input logic [`MDU_TAG_BITS-1:0]   tag
    );
        logic [31:0]  exp_rd;
        logic         exp_ill;
        mdu_model(word, a, b, exp_rd, exp_ill);
        start  = 1'b1;
        instr  = word;
        rs1_v  = a;
        rs2_v  = b;
        tag_in = tag;
        start_q.push_back(cycle_cnt + 1);
        lat_q.push_back(exp_ill ? 1 : (word.r.funct3[2] ? DIV_LAT : MUL_LAT));
        rd_q.push_back(exp_rd);
        ill_q.push_back(exp_ill);
        tag_q.push_back(tag);
        op_count++;
        @(posedge clk);
        #DRIVE_DELAY;
        // scramble the inputs so that only latched values can give the result.
        start     = 1'b0;
        instr.raw = $random(seed);
        rs1_v     = $random(seed);
        rs2_v     = $random(seed);
        tag_in    = random_tag();
        while (!done) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // *******************************************************************
    // comparison, mid-cycle
    // *******************************************************************

    always @(negedge clk) begin
        int elapsed;
        if (rst_n) begin
            elapsed = (start_q.size() == 0) ? -1 : cycle_cnt - start_q[0];
            if (elapsed < 0) begin
                check_count++;
                assert (!busy && !done) else begin
                    error_count++;
                    $display("busy or done high with nothing in flight at cycle %0d", cycle_cnt);
                end
                if (op_count == 0) begin
                    compare_word("illegal", 32'(illegal), 32'h0);
                    compare_word("rd_v", rd_v, 32'h0);
                    compare_word("tag_out", 32'(tag_out), 32'h0);
                end
            end else if (elapsed < lat_q[0]) begin
                check_count++;
                assert (busy && !done) else begin
                    error_count++;
                    $display("busy low or done early %0d cycles after start", elapsed);
                end
            end else begin
                check_count++;
                assert (done && !busy) else begin
                    error_count++;
                    $display("done missing or busy high %0d cycles after start", elapsed);
                end
                if (done) begin
                    compare_word("rd_v", rd_v, rd_q[0]);
                    compare_word("illegal", 32'(illegal), 32'(ill_q[0]));
                    compare_word("tag_out", 32'(tag_out), 32'(tag_q[0]));
                end
                void'(start_q.pop_front());
                void'(lat_q.pop_front());
                void'(rd_q.pop_front());
                void'(ill_q.pop_front());
                void'(tag_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    // *******************************************************************
    // test sequence
    // *******************************************************************

    initial begin
        int           f;
        int           i;
        int           j;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [6:0]   f7;
        seed      = 81;
        start     = 1'b0;
        instr.raw = '0;
        rs1_v     = '0;
        rs2_v     = '0;
        tag_in    = '0;
        corner    = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        @(posedge rst_n);
        @(posedge clk);
        #DRIVE_DELAY;

        // corner values through all eight forms, overflow and divide by zero included.
        for (f = 0; f < 8; f++) begin
            for (i = 0; i < 5; i++) begin
                for (j = 0; j < 5; j++) begin
                    issue_op(encode_r(rv32m_pkg::FUNCT7_MULDIV, 3'(f), rv32m_pkg::OP_REG),
                             corner[i], corner[j], random_tag());
                end
            end
        end
        idle_cycles(3);

        for (i = 0; i < NUM_RANDOM; i++) begin
            a = $random(seed);
            b = $random(seed);
            for (f = 0; f < 4; f++) begin
                issue_op(encode_r(rv32m_pkg::FUNCT7_MULDIV, 3'(f), rv32m_pkg::OP_REG),
                         a, b, random_tag());
            end
        end
        idle_cycles(2);

        // narrower divisors half the time, for larger quotients.
        for (i = 0; i < NUM_RANDOM; i++) begin
            a = $random(seed);
            b = $random(seed);
            if (i % 2 == 1) begin
                b = b >> (i % 31);
            end
            for (f = 4; f < 8; f++) begin
                issue_op(encode_r(rv32m_pkg::FUNCT7_MULDIV, 3'(f), rv32m_pkg::OP_REG),
                         a, b, random_tag());
            end
        end
        idle_cycles(1);

        for (f = 4; f < 8; f++) begin
            issue_op(encode_r(rv32m_pkg::FUNCT7_MULDIV, 3'(f), rv32m_pkg::OP_REG),
                     $random(seed), 32'h0, random_tag());
            issue_op(encode_r(rv32m_pkg::FUNCT7_MULDIV, 3'(f), rv32m_pkg::OP_REG),
                     32'h8000_0000, 32'h0, random_tag());
            issue_op(encode_r(rv32m_pkg::FUNCT7_MULDIV, 3'(f), rv32m_pkg::OP_REG),
                     32'h8000_0000, 32'hffff_ffff, random_tag());
        end

        // wrong opcode, then wrong funct7.
        for (i = 0; i < 4; i++) begin
            issue_op(encode_r(rv32m_pkg::FUNCT7_MULDIV, 3'(2 * i),
                              rv32m_pkg::OP_REG ^ (7'h1 << i)),
                     $random(seed), $random(seed), random_tag());
            issue_op(encode_r(rv32m_pkg::FUNCT7_MULDIV ^ (7'h1 << i), 3'(2 * i + 1),
                              rv32m_pkg::OP_REG),
                     $random(seed), $random(seed), random_tag());
        end

        // mixed back-to-back traffic.
        for (i = 0; i < 20; i++) begin
            f7 = (i % 5 == 4) ? 7'h00 : rv32m_pkg::FUNCT7_MULDIV;
            issue_op(encode_r(f7, 3'($random(seed)), rv32m_pkg::OP_REG),
                     $random(seed), $random(seed), random_tag());
        end

        @(negedge clk);
        #1;
        assert ((start_q.size() == 0) && (op_count == NUM_OPS)) else begin
            run_errors++;
            $display("Operation count is off or results are still pending: %0d issued, %0d pending",
                     op_count, start_q.size());
        end
        $display("Summary: %0d operations, %0d checks, %0d result errors, %0d run errors",
                 op_count, check_count, error_count, run_errors);
        if ((error_count == 0) && (run_errors == 0)) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_mdu

`default_nettype wire

/* sources.f */
+incdir+hdl
hdl/rv32m_pkg.sv
hdl/mult_seq.sv
hdl/fu_mult.sv
hdl/fu_div.sv
hdl/mdu_top.sv
tests/tb_clock.sv
tests/tb_mdu.sv

/* Makefile */
# Verilator build and run for the RV32M execution unit testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_mdu
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
